/* filelist.f */
qpix_ctrl_pkg.sv
timestamp_unit.sv
timestamp_fifo.sv
hit_channel.sv
serial_loader.sv
qpix_apb_regs.sv
qpix_ctrl_top.sv
tb_qpix_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result judged from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_qpix_ctrl -o tb_qpix_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_qpix_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0

/* tb_qpix_ctrl.sv */
`timescale 1ns/1ps

module tb_qpix_ctrl
    import qpix_ctrl_pkg::*;
();

    // Timeout and hit path latency in clk200 cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int HIT_LATENCY    = 3;

    logic       clk200;
    logic       counter_reset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    ch_mask_t   hit_lvds;
    logic       trigger;
    logic       ext_por;
    logic       rst_ext;
    logic       startup;
    logic       ser_data;
    logic       ser_clk;

    // Bookkeeping
    int          errors;
    int          err_mark;
    int          tests_run;
    int          tests_failed;
    int unsigned cycle;
    // Expected counter value, same reset and count rule as the DUT
    timestamp_t  ts_model;
    // Count right after the access edge of the last write
    timestamp_t  last_wr_ts;
    logic [31:0] rnd;

    // Serial compare state
    apb_data_t   ser_word_exp;
    int          ser_base;
    int          ser_pulses;
    int          ser_errors;

    qpix_ctrl_top uut (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .hit_lvds      (hit_lvds),
        .trigger       (trigger),
        .ext_por       (ext_por),
        .rst_ext       (rst_ext),
        .startup       (startup),
        .ser_data      (ser_data),
        .ser_clk       (ser_clk)
    );

    initial
    begin
        clk200 = 1'b0;
        forever #5 clk200 = ~clk200;
    end

    ////////////////////////////////////////////////////////////
    // Reference model and random source
    ////////////////////////////////////////////////////////////

    // Word stored for a hit raised while ts_model read drive_ts
    function automatic timestamp_t hit_word(input timestamp_t drive_ts);
        return drive_ts + timestamp_t'(HIT_LATENCY);
    endfunction

    // Bit idx of the serial stream, MSB first
    function automatic logic expected_ser_bit(input apb_data_t w, input int idx);
        return w[SER_BITS-1-idx];
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk200)
    begin
        if (counter_reset)
        begin
            ts_model <= '0;
        end
        else
        begin
            ts_model <= ts_model + 1'b1;
        end
    end

    // Cycle limit
    always @(posedge clk200)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Serial stream checker, one bit per rising ser_clk
    always @(posedge ser_clk)
    begin : ser_compare
        int idx;
        idx = ser_pulses - ser_base;
        if (idx >= SER_BITS)
        begin
            $display("Extra serial clock pulse at %0t after %0d bits", $time, idx);
            ser_errors = ser_errors + 1;
        end
        else if (ser_data !== expected_ser_bit(ser_word_exp, idx))
        begin
            $display("Mismatch at %0t: ser_data bit %0d got %b expected %b",
                     $time, idx, ser_data, expected_ser_bit(ser_word_exp, idx));
            ser_errors = ser_errors + 1;
        end
        ser_pulses = ser_pulses + 1;
    end

    ////////////////////////////////////////////////////////////
    // Bus tasks and checks
    ////////////////////////////////////////////////////////////

    // Called at a falling edge, returns at a falling edge
    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk200);
        penable = 1'b1;
        @(negedge clk200);
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        last_wr_ts = ts_model;
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk200);
        penable = 1'b1;
        // Mid access phase, away from any clock edge
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge clk200);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_head(input int ch, output timestamp_t value);
        apb_data_t hi;
        apb_data_t lo;
        logic      err;
        read_reg(apb_addr_t'(ADDR_HEAD_BASE + 8 * ch), hi, err);
        read_reg(apb_addr_t'(ADDR_HEAD_BASE + 8 * ch + 4), lo, err);
        value = {hi, lo};
    endtask

    task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_stamp(input string name, input timestamp_t got, input timestamp_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got 0x%016h expected 0x%016h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic finish_test(input string name);
        int total;
        total = errors + ser_errors;
        tests_run = tests_run + 1;
        if (total != err_mark)
        begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %0d %s finished with %0d errors", tests_run, name, total - err_mark);
        err_mark = total;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        apb_data_t  d;
        logic       err;
        timestamp_t t1;
        timestamp_t t2;
        timestamp_t t0b;
        timestamp_t h0;
        timestamp_t h1;
        timestamp_t prev;
        timestamp_t sent [FIFO_DEPTH+2];
        int         gap;
        int         popped;
        apb_data_t  word;

        counter_reset = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        hit_lvds      = '0;
        errors        = 0;
        err_mark      = 0;
        tests_run     = 0;
        tests_failed  = 0;
        cycle         = 0;
        rnd           = 32'd67;
        ser_word_exp  = '0;
        ser_base      = 0;
        ser_pulses    = 0;
        ser_errors    = 0;
        repeat (5) @(negedge clk200);
        counter_reset = 1'b0;
        @(negedge clk200);

        // Reset values, ID and unmapped address
        check_word("pads", apb_data_t'({trigger, ext_por, rst_ext, startup, ser_clk, ser_data}),
                   '0);
        read_reg(ADDR_ID, d, err);
        check_word("id", d, ID_VALUE);
        if (err !== 1'b0 || pready !== 1'b1)
        begin
            report_error("ID read not completed cleanly");
        end
        read_reg(ADDR_CTRL, d, err);
        check_word("ctrl", d, '0);
        read_reg(ADDR_FIFO_STATUS, d, err);
        check_word("fifo_status", d, apb_data_t'((1 << NUM_CH) - 1));
        read_reg(8'h40, d, err);
        if (err !== 1'b1)
        begin
            report_error("no pslverr on read of unmapped address 0x40");
        end
        finish_test("reset");

        // Pad bits follow the control register
        write_reg(ADDR_CTRL, 32'hE);
        check_word("pads", apb_data_t'({startup, rst_ext, ext_por, trigger}), 32'hE);
        read_reg(ADDR_CTRL, d, err);
        check_word("ctrl", d, 32'hE);
        write_reg(ADDR_CTRL, 32'h0);
        // Two trigger edges N cycles apart
        write_reg(ADDR_CTRL, 32'h1);
        t1 = last_wr_ts;
        write_reg(ADDR_CTRL, 32'h0);
        read_reg(ADDR_TRIG_HI, d, err);
        h0[63:32] = d;
        read_reg(ADDR_TRIG_LO, d, err);
        h0[31:0] = d;
        check_stamp("trig_timestamp first", h0, t1);
        rnd = lcg_next(rnd);
        gap = 3 + int'(rnd % 32'd20);
        repeat (gap) @(negedge clk200);
        write_reg(ADDR_CTRL, 32'h1);
        t2 = last_wr_ts;
        read_reg(ADDR_TRIG_HI, d, err);
        h1[63:32] = d;
        read_reg(ADDR_TRIG_LO, d, err);
        h1[31:0] = d;
        check_stamp("trig_timestamp second", h1, t2);
        // Access edges: clear write 2, two reads 4, gap, then the write 2
        check_stamp("trigger spacing", h1 - h0, timestamp_t'(gap + 8));
        write_reg(ADDR_CTRL, 32'h0);
        finish_test("trigger");

        // Hits on channels 0 and 1, channel 0 held high for a long time
        rnd = lcg_next(rnd);
        gap = 2 + int'(rnd % 32'd5);
        hit_lvds[0] = 1'b1;
        t1 = ts_model;
        repeat (gap) @(negedge clk200);
        hit_lvds[1] = 1'b1;
        t2 = ts_model;
        repeat (3) @(negedge clk200);
        hit_lvds[1] = 1'b0;
        repeat (12) @(negedge clk200);
        hit_lvds[0] = 1'b0;
        repeat (4) @(negedge clk200);
        hit_lvds[0] = 1'b1;
        t0b = ts_model;
        repeat (3) @(negedge clk200);
        hit_lvds[0] = 1'b0;
        repeat (6) @(negedge clk200);
        read_head(0, h0);
        check_stamp("head ch0", h0, hit_word(t1));
        read_head(1, h1);
        check_stamp("head ch1", h1, hit_word(t2));
        check_stamp("head ch1 minus ch0", h1 - h0, timestamp_t'(gap));
        write_reg(ADDR_FIFO_POP, 32'h1);
        read_head(0, h0);
        check_stamp("head ch0 second", h0, hit_word(t0b));
        write_reg(ADDR_FIFO_POP, 32'h1);
        read_reg(ADDR_FIFO_STATUS, d, err);
        check_word("fifo_status after ch0 pops", d, 32'hD);
        write_reg(ADDR_FIFO_POP, 32'h2);
        read_reg(ADDR_FIFO_STATUS, d, err);
        check_word("fifo_status after ch1 pop", d, 32'hF);
        finish_test("hit capture");

        // Overfill channel 2
        for (int i = 0; i < FIFO_DEPTH + 2; i++)
        begin
            hit_lvds[2] = 1'b1;
            sent[i] = ts_model;
            repeat (3) @(negedge clk200);
            hit_lvds[2] = 1'b0;
            repeat (3) @(negedge clk200);
        end
        repeat (6) @(negedge clk200);
        read_reg(ADDR_FIFO_STATUS, d, err);
        check_word("fifo_status full", d, apb_data_t'(32'hB | (32'h4 << STATUS_FULL_LSB)));
        popped = 0;
        prev   = '0;
        while (!d[2] && popped < FIFO_DEPTH + 4)
        begin
            read_head(2, h0);
            if (popped < FIFO_DEPTH)
            begin
                check_stamp("head ch2", h0, hit_word(sent[popped]));
            end
            if (popped > 0 && h0 <= prev)
            begin
                report_error("channel 2 words not strictly increasing");
            end
            prev = h0;
            write_reg(ADDR_FIFO_POP, 32'h4);
            popped = popped + 1;
            read_reg(ADDR_FIFO_STATUS, d, err);
        end
        check_word("words popped from ch2", apb_data_t'(popped), apb_data_t'(FIFO_DEPTH));
        check_word("fifo_status drained", d, 32'hF);
        finish_test("fifo full");

        // Serial loader
        rnd  = lcg_next(rnd);
        word = rnd;
        ser_word_exp = word;
        ser_base     = ser_pulses;
        write_reg(ADDR_SER_DATA, word);
        read_reg(ADDR_SER_DATA, d, err);
        check_word("ser_word", d, word);
        write_reg(ADDR_SER_CMD, 32'h1);
        write_reg(ADDR_SER_CMD, 32'h2);
        repeat (4) @(negedge clk200);
        read_reg(ADDR_SER_CMD, d, err);
        check_word("busy during transfer", d, 32'h1);
        // Load and transmit while busy must change nothing
        write_reg(ADDR_SER_DATA, ~word);
        write_reg(ADDR_SER_CMD, 32'h3);
        d = 32'h1;
        while (d[0])
        begin
            read_reg(ADDR_SER_CMD, d, err);
        end
        repeat (20) @(negedge clk200);
        read_reg(ADDR_SER_CMD, d, err);
        check_word("busy after transfer", d, 32'h0);
        check_word("serial clock pulses", apb_data_t'(ser_pulses - ser_base),
                   apb_data_t'(SER_BITS));
        finish_test("serial loader");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors + ser_errors);
        if (errors + ser_errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* qpix_ctrl_top.sv */
`timescale 1ns/1ps

module qpix_ctrl_top
    import qpix_ctrl_pkg::*;
(
    input  logic      clk200,
    input  logic      counter_reset,
    // APB slave
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    // Hit lines from the chip, asynchronous
    input  ch_mask_t  hit_lvds,
    // Pads
    output logic      trigger,
    output logic      ext_por,
    output logic      rst_ext,
    output logic      startup,
    output logic      ser_data,
    output logic      ser_clk
);

    timestamp_t timestamp;
    timestamp_t trig_timestamp;
    timestamp_t heads [NUM_CH];
    ch_mask_t   empty;
    ch_mask_t   full;
    ch_mask_t   pop;
    apb_data_t  ser_word;
    logic       ser_load;
    logic       ser_xmit;
    logic       ser_busy;

    ////////////////////////////////////////////////////////////
    // Register block
    ////////////////////////////////////////////////////////////

    qpix_apb_regs u_regs (
        .clk200         (clk200),
        .counter_reset  (counter_reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .trig_timestamp (trig_timestamp),
        .heads          (heads),
        .empty          (empty),
        .full           (full),
        .ser_busy       (ser_busy),
        .trigger        (trigger),
        .ext_por        (ext_por),
        .rst_ext        (rst_ext),
        .startup        (startup),
        .ser_word       (ser_word),
        .ser_load       (ser_load),
        .ser_xmit       (ser_xmit),
        .pop            (pop)
    );

    // Timestamp counter, trigger capture
    timestamp_unit u_ts (
        .clk200         (clk200),
        .counter_reset  (counter_reset),
        .trigger        (trigger),
        .timestamp      (timestamp),
        .trig_timestamp (trig_timestamp)
    );

    // Configuration word to the pixel chip
    serial_loader u_loader (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .load          (ser_load),
        .xmit          (ser_xmit),
        .word          (ser_word),
        .ser_data      (ser_data),
        .ser_clk       (ser_clk),
        .busy          (ser_busy)
    );

    // One channel per hit line, all stamped from the same counter
    for (genvar g = 0; g < NUM_CH; g++)
    begin : g_ch
        hit_channel u_ch (
            .clk200        (clk200),
            .counter_reset (counter_reset),
            .hit_in        (hit_lvds[g]),
            .timestamp     (timestamp),
            .pop           (pop[g]),
            .head          (heads[g]),
            .empty         (empty[g]),
            .full          (full[g])
        );
    end

endmodule

/* qpix_apb_regs.sv */
`timescale 1ns/1ps

module qpix_apb_regs
    import qpix_ctrl_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    // APB slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    // Read-only state
    input  timestamp_t trig_timestamp,
    input  timestamp_t heads [NUM_CH],
    input  ch_mask_t   empty,
    input  ch_mask_t   full,
    input  logic       ser_busy,
    // Pad controls
    output logic       trigger,
    output logic       ext_por,
    output logic       rst_ext,
    output logic       startup,
    // Loader and FIFO controls
    output apb_data_t  ser_word,
    output logic       ser_load,
    output logic       ser_xmit,
    output ch_mask_t   pop
);

    logic access;
    logic wr_en;
    logic addr_hit;

    // Access phase of a transfer, no wait states
    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign pready = 1'b1;

    ////////////////////////////////////////////////////////////
    // Address decode and read multiplexer
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            ADDR_CTRL:
            begin
                prdata[CTRL_TRIGGER] = trigger;
                prdata[CTRL_EXT_POR] = ext_por;
                prdata[CTRL_RST_EXT] = rst_ext;
                prdata[CTRL_STARTUP] = startup;
            end
            ADDR_SER_CMD:     prdata[0] = ser_busy;
            ADDR_SER_DATA:    prdata = ser_word;
            // Pop register is write only, reads as zero
            ADDR_FIFO_POP:    prdata = '0;
            ADDR_TRIG_HI:     prdata = trig_timestamp[TS_WIDTH-1 -: APB_DATA_WIDTH];
            ADDR_TRIG_LO:     prdata = trig_timestamp[APB_DATA_WIDTH-1:0];
            ADDR_FIFO_STATUS:
            begin
                prdata[NUM_CH-1:0]               = empty;
                prdata[STATUS_FULL_LSB +: NUM_CH] = full;
            end
            ADDR_ID:          prdata = ID_VALUE;
            default:
            begin
                // Head words, two per channel
                addr_hit = 1'b0;
                for (int n = 0; n < NUM_CH; n++)
                begin
                    if (paddr == apb_addr_t'(ADDR_HEAD_BASE + 8 * n))
                    begin
                        addr_hit = 1'b1;
                        prdata   = heads[n][TS_WIDTH-1 -: APB_DATA_WIDTH];
                    end
                    if (paddr == apb_addr_t'(ADDR_HEAD_BASE + 8 * n + 4))
                    begin
                        addr_hit = 1'b1;
                        prdata   = heads[n][APB_DATA_WIDTH-1:0];
                    end
                end
            end
        endcase
    end

    // Unmapped address, flagged only in the access phase
    assign pslverr = access & ~addr_hit;

    ////////////////////////////////////////////////////////////
    // Writable registers and one-cycle strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            trigger  <= 1'b0;
            ext_por  <= 1'b0;
            rst_ext  <= 1'b0;
            startup  <= 1'b0;
            ser_word <= '0;
            ser_load <= 1'b0;
            ser_xmit <= 1'b0;
            pop      <= '0;
        end
        else
        begin
            // Strobes drop after one cycle
            ser_load <= 1'b0;
            ser_xmit <= 1'b0;
            pop      <= '0;
            if (wr_en)
            begin
                case (paddr)
                    ADDR_CTRL:
                    begin
                        trigger <= pwdata[CTRL_TRIGGER];
                        ext_por <= pwdata[CTRL_EXT_POR];
                        rst_ext <= pwdata[CTRL_RST_EXT];
                        startup <= pwdata[CTRL_STARTUP];
                    end
                    ADDR_SER_CMD:
                    begin
                        ser_load <= pwdata[CMD_LOAD];
                        ser_xmit <= pwdata[CMD_XMIT];
                    end
                    ADDR_SER_DATA: ser_word <= pwdata;
                    ADDR_FIFO_POP: pop <= pwdata[NUM_CH-1:0];
                    // Read-only and unmapped addresses are left alone
                    default: ;
                endcase
            end
        end
    end

endmodule

/* serial_loader.sv */
`timescale 1ns/1ps

module serial_loader
    import qpix_ctrl_pkg::*;
(
    input  logic      clk200,
    input  logic      counter_reset,
    input  logic      load,
    input  logic      xmit,
    input  apb_data_t word,
    output logic      ser_data,
    output logic      ser_clk,
    output logic      busy
);

    ser_state_t               state;
    // Shift register, MSB goes out first
    apb_data_t                shreg;
    // Cycles spent in the current half period
    logic [SER_DIV_WIDTH-1:0] div_cnt;
    // Bits already sent
    logic [SER_CNT_WIDTH-1:0] bit_cnt;
    logic                     half_done;
    logic                     bit_done;

    assign half_done = (div_cnt == SER_DIV_WIDTH'(SER_HALF_PERIOD - 1));
    // End of the high phase closes one serial clock period
    assign bit_done  = half_done & ser_clk;

    ////////////////////////////////////////////////////////////
    // State machine, divider and bit counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            state   <= SER_IDLE;
            ser_clk <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                SER_IDLE:
                begin
                    ser_clk <= 1'b0;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    if (xmit)
                    begin
                        state <= SER_SHIFT;
                    end
                end
                SER_SHIFT:
                begin
                    if (half_done)
                    begin
                        div_cnt <= '0;
                        // Low half sets up the bit, high half presents the edge
                        ser_clk <= ~ser_clk;
                        if (ser_clk)
                        begin
                            if (bit_cnt == SER_CNT_WIDTH'(SER_BITS - 1))
                            begin
                                state <= SER_IDLE;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Load only while idle, shift at the falling serial clock
    always_ff @(posedge clk200)
    begin
        if (state == SER_IDLE)
        begin
            if (load)
            begin
                shreg <= word;
            end
        end
        else if (bit_done)
        begin
            shreg <= {shreg[SER_BITS-2:0], 1'b0};
        end
    end

    assign busy     = (state == SER_SHIFT);
    // Data line stays low outside a transfer
    assign ser_data = busy & shreg[SER_BITS-1];

endmodule

/* hit_channel.sv */
`timescale 1ns/1ps

module hit_channel
    import qpix_ctrl_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    input  logic       hit_in,
    input  timestamp_t timestamp,
    input  logic       pop,
    output timestamp_t head,
    output logic       empty,
    output logic       full
);

    // Two-flop synchronizer
    logic hit_meta;
    logic hit_sync;
    // Edge detect and registered one-shot
    logic hit_sync_d;
    logic hit_pulse;
    logic push;

    ////////////////////////////////////////////////////////////
    // Synchronizer and rising-edge one-shot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            hit_meta   <= 1'b0;
            hit_sync   <= 1'b0;
            hit_sync_d <= 1'b0;
            hit_pulse  <= 1'b0;
        end
        else
        begin
            hit_meta   <= hit_in;
            hit_sync   <= hit_meta;
            hit_sync_d <= hit_sync;
            // Single cycle per rising edge, however long the hit stays high
            hit_pulse  <= hit_sync & ~hit_sync_d;
        end
    end

    // Hit is lost when the FIFO has no room
    assign push = hit_pulse & ~full;

    timestamp_fifo u_fifo (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .push          (push),
        .push_data     (timestamp),
        .pop           (pop),
        .head          (head),
        .empty         (empty),
        .full          (full)
    );

endmodule

/* timestamp_fifo.sv */
`timescale 1ns/1ps

module timestamp_fifo
    import qpix_ctrl_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    input  logic       push,
    input  timestamp_t push_data,
    input  logic       pop,
    output timestamp_t head,
    output logic       empty,
    output logic       full
);

    // Circular buffer storage
    timestamp_t                mem [FIFO_DEPTH];
    fifo_ptr_t                 wr_ptr;
    fifo_ptr_t                 rd_ptr;
    // Occupancy, one bit wider than the pointers
    logic [FIFO_PTR_WIDTH:0]   count;
    logic [FIFO_PTR_WIDTH:0]   count_next;
    logic                      do_pop;

    // Pop on an empty FIFO does nothing
    assign do_pop = pop & ~empty;

    // Push and pop together leave the count unchanged
    always_comb
    begin
        count_next = count;
        case ({push, do_pop})
            2'b10: count_next = count + 1'b1;
            2'b01: count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // Write port, the caller never pushes into a full FIFO
    always_ff @(posedge clk200)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and registered flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end
        else
        begin
            // Pointers wrap naturally at FIFO_DEPTH
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
        end
    end

    // Oldest word, moves one cycle after a pop
    assign head = mem[rd_ptr];

endmodule

/* timestamp_unit.sv */
`timescale 1ns/1ps

module timestamp_unit
    import qpix_ctrl_pkg::*;
(
    input  logic       clk200,
    input  logic       counter_reset,
    input  logic       trigger,
    output timestamp_t timestamp,
    output timestamp_t trig_timestamp
);

    // Trigger as seen one cycle earlier
    logic trig_d;

    ////////////////////////////////////////////////////////////
    // Free-running counter and trigger capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            timestamp      <= '0;
            trig_d         <= 1'b0;
            trig_timestamp <= '0;
        end
        else
        begin
            // Counts every cycle, wraps after 2^64
            timestamp <= timestamp + 1'b1;
            trig_d    <= trigger;
            // Rising edge of the trigger latches the current count
            if (trigger && !trig_d)
            begin
                trig_timestamp <= timestamp;
            end
        end
    end

endmodule

/* qpix_ctrl_pkg.sv */
package qpix_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    localparam int TS_WIDTH        = 64;
    localparam int APB_DATA_WIDTH  = 32;
    // Byte address
    localparam int APB_ADDR_WIDTH  = 8;
    localparam int NUM_CH          = 4;
    localparam int FIFO_DEPTH      = 8;
    localparam int FIFO_PTR_WIDTH  = 3;

    // Serial loader timing
    localparam int SER_BITS        = 32;
    localparam int SER_HALF_PERIOD = 2;
    localparam int SER_DIV_WIDTH   = $clog2(SER_HALF_PERIOD + 1);
    localparam int SER_CNT_WIDTH   = $clog2(SER_BITS);

    ////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////

    typedef logic [TS_WIDTH-1:0]       timestamp_t;
    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
    typedef logic [NUM_CH-1:0]         ch_mask_t;
    typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;

    typedef enum logic {
        SER_IDLE,
        SER_SHIFT
    } ser_state_t;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam apb_addr_t ADDR_CTRL        = 8'h00;
    localparam apb_addr_t ADDR_SER_CMD     = 8'h04;
    localparam apb_addr_t ADDR_SER_DATA    = 8'h08;
    localparam apb_addr_t ADDR_FIFO_POP    = 8'h0C;
    localparam apb_addr_t ADDR_TRIG_HI     = 8'h10;
    localparam apb_addr_t ADDR_TRIG_LO     = 8'h14;
    localparam apb_addr_t ADDR_FIFO_STATUS = 8'h18;
    // Channel n upper half at base + 8n, lower half 4 above it
    localparam apb_addr_t ADDR_HEAD_BASE   = 8'h20;
    localparam apb_addr_t ADDR_ID          = 8'h7C;

    // Bit positions inside the control and command words
    localparam int CTRL_TRIGGER    = 0;
    localparam int CTRL_EXT_POR    = 1;
    localparam int CTRL_RST_EXT    = 2;
    localparam int CTRL_STARTUP    = 3;
    localparam int CMD_LOAD        = 0;
    localparam int CMD_XMIT        = 1;
    // Full flags start here in the status word
    localparam int STATUS_FULL_LSB = 16;

    localparam apb_data_t ID_VALUE = 32'h5150_0C04;

endpackage
